// File: logic/fabric_settings.svh
/*
 * bus widths, address map, sram depth and reset stretch length
 * for the single-master ahb-lite fabric
 */
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// bus widths
`define FABRIC_HADDR_W       32
`define FABRIC_HDATA_W       32

// slave hit when masked address equals base
`define FABRIC_SRAM_BASE     32'h2000_0000
`define FABRIC_SRAM_MASK     32'hE000_0000   // 512 MB window
`define FABRIC_TIMER_BASE    32'h4000_0400
`define FABRIC_TIMER_MASK    32'hFFFF_FFC0   // 64 byte window

// sram size in words
`define FABRIC_SRAM_DEPTH    512

// clocks from external release to bus release
`define FABRIC_RST_STRETCH   5

`endif

// File: logic/fabric_pkg.sv
/*
 * bus word types, ahb-lite transfer encodings
 * and timer register offsets
 */
`include "fabric_settings.svh"

package fabric_pkg;

   // bus words
   typedef logic [`FABRIC_HADDR_W-1:0] haddr_t;
   typedef logic [`FABRIC_HDATA_W-1:0] hdata_t;

   // htrans encoding
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_t;

   typedef logic [2:0] hsize_t;
   localparam hsize_t HSIZE_WORD = 3'b010;   // only size the slaves accept

   // timer register map, byte offsets
   typedef enum logic [3:0] {
      TIMER_CTRL = 4'h0,   // bit 0 enable
      TIMER_CMP  = 4'h4,
      TIMER_CNT  = 4'h8,
      TIMER_STAT = 4'hC    // bit 0 match flag, w1c
   } timer_reg_t;

endpackage

// File: logic/reset_stretch.sv
/*
 * bus reset generator
 * async assertion, release synchronous and delayed
 */
`timescale 1ns/1ns
`include "fabric_settings.svh"

module reset_stretch (
   input  logic hclk_i,
   input  logic rst_n_i,      // external reset, async
   output logic hreset_n_o    // bus reset
);

   ////////////////////////////////////////////////////////////////////////////
   // release shift register

   logic [`FABRIC_RST_STRETCH-1:0] stretch_q;   // fills with ones after release

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stretch_q <= '0;                       // assertion is immediate
      end else begin
         stretch_q <= {stretch_q[`FABRIC_RST_STRETCH-2:0], 1'b1};
      end
   end

   // last stage drives the bus
   // high on the 5th rising edge after release
   assign hreset_n_o = stretch_q[`FABRIC_RST_STRETCH-1];

endmodule

// File: logic/ahb_decoder.sv
/*
 * ahb-lite address decoder for one master
 * slave selects, data phase target, read mux, default error slave
 */
`timescale 1ns/1ns
`include "fabric_settings.svh"

module ahb_decoder import fabric_pkg::*; (
   input  logic    hclk_i,
   input  logic    hreset_n_i,
   input  haddr_t  haddr_i,        // address phase
   input  htrans_t htrans_i,
   input  hdata_t  sram_rdata_i,
   input  hdata_t  timer_rdata_i,
   output logic    sram_sel_o,     // address phase select levels
   output logic    timer_sel_o,
   output hdata_t  hrdata_o,       // to master
   output logic    hready_o,       // combined ready, also to slaves
   output logic    hresp_o
);

   typedef enum logic [1:0] {TGT_NONE, TGT_SRAM, TGT_TIMER, TGT_DEFAULT} target_t;

   target_t addr_tgt;       // slave hit by the address phase
   target_t data_tgt_q;     // slave owning the data phase
   logic    addr_accept;
   logic    err_first;      // error cycle 1, stall
   logic    err_second_q;   // error cycle 2, release

   ////////////////////////////////////////////////////////////////////////////
   // address phase

   assign sram_sel_o  = (haddr_i & `FABRIC_SRAM_MASK)  == `FABRIC_SRAM_BASE;
   assign timer_sel_o = (haddr_i & `FABRIC_TIMER_MASK) == `FABRIC_TIMER_BASE;

   always_comb begin
      if (sram_sel_o)       addr_tgt = TGT_SRAM;
      else if (timer_sel_o) addr_tgt = TGT_TIMER;
      else                  addr_tgt = TGT_DEFAULT;   // unmapped
   end

   assign addr_accept = hready_o && (htrans_i == NONSEQ || htrans_i == SEQ);

   ////////////////////////////////////////////////////////////////////////////
   // data phase and default slave

   always_ff @(posedge hclk_i or negedge hreset_n_i) begin
      if (!hreset_n_i) begin
         data_tgt_q   <= TGT_NONE;
         err_second_q <= 1'b0;
      end else begin
         err_second_q <= err_first;
         if (hready_o) begin                         // held during the stall
            data_tgt_q <= addr_accept ? addr_tgt : TGT_NONE;
         end
      end
   end

   assign err_first = (data_tgt_q == TGT_DEFAULT) && !err_second_q;
   assign hresp_o   = (data_tgt_q == TGT_DEFAULT);    // both error cycles
   assign hready_o  = hreset_n_i && !err_first;       // bus held while in reset

   always_comb begin
      case (data_tgt_q)
         TGT_SRAM:  hrdata_o = sram_rdata_i;
         TGT_TIMER: hrdata_o = timer_rdata_i;
         default:   hrdata_o = '0;
      endcase
   end

   // address map windows must not overlap
   a_sel_onehot: assert property (@(posedge hclk_i) disable iff (!hreset_n_i)
      $onehot0({sram_sel_o, timer_sel_o}));

   // after a clean data phase an error opens with its stall cycle
   a_resp_cause: assert property (@(posedge hclk_i) disable iff (!hreset_n_i)
      hresp_o && $past(hready_o && !hresp_o) |-> !hready_o);

endmodule

// File: logic/ahb_sram.sv
/*
 * ahb-lite sram slave, word access only
 * zero wait states, aliases across its window
 */
`timescale 1ns/1ns
`include "fabric_settings.svh"

module ahb_sram import fabric_pkg::*; (
   input  logic    hclk_i,
   input  logic    hreset_n_i,
   input  logic    sel_i,        // from decoder
   input  haddr_t  haddr_i,
   input  htrans_t htrans_i,
   input  hsize_t  hsize_i,
   input  logic    hwrite_i,
   input  hdata_t  hwdata_i,     // data phase
   input  logic    hready_i,     // combined ready
   output hdata_t  hrdata_o
);

   localparam int IDX_W = $clog2(`FABRIC_SRAM_DEPTH);

   hdata_t           mem [`FABRIC_SRAM_DEPTH];
   logic [IDX_W-1:0] addr_q;     // word index of the data phase
   logic             wr_pend_q;  // data phase is a write
   logic             accept;

   // valid transfer to this slave
   assign accept = sel_i && hready_i && (htrans_i == NONSEQ || htrans_i == SEQ);

   ////////////////////////////////////////////////////////////////////////////
   // address phase capture

   always_ff @(posedge hclk_i or negedge hreset_n_i) begin
      if (!hreset_n_i) begin
         wr_pend_q <= 1'b0;
      end else if (hready_i) begin
         wr_pend_q <= accept && hwrite_i;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (accept) begin
         addr_q <= haddr_i[IDX_W+1:2];   // upper index bits dropped
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // data phase

   always_ff @(posedge hclk_i) begin
      if (wr_pend_q && hready_i) begin
         mem[addr_q] <= hwdata_i;        // lands at end of data phase
      end
   end

   assign hrdata_o = mem[addr_q];        // async read

   // no byte lanes in this fabric
   a_word_only: assert property (@(posedge hclk_i) disable iff (!hreset_n_i)
      accept |-> hsize_i == HSIZE_WORD);

endmodule

// File: logic/ahb_timer.sv
/*
 * ahb-lite timer slave, one channel
 * ctrl, cmp, cnt and stat registers, match interrupt
 */
`timescale 1ns/1ns

module ahb_timer import fabric_pkg::*; (
   input  logic    hclk_i,
   input  logic    hreset_n_i,
   input  logic    sel_i,
   input  haddr_t  haddr_i,
   input  htrans_t htrans_i,
   input  hsize_t  hsize_i,
   input  logic    hwrite_i,
   input  hdata_t  hwdata_i,
   input  logic    hready_i,
   output hdata_t  hrdata_o,
   output logic    irq_o        // level, follows stat bit 0
);

   hdata_t     ctrl_q;
   hdata_t     cmp_q;
   hdata_t     cnt_q;
   logic       stat_q;
   timer_reg_t off_q;          // register of the data phase
   logic       wr_pend_q;
   logic       accept;
   logic       wr_fire;        // bus write this cycle
   logic       wrap;
   logic       stat_clr;

   assign accept   = sel_i && hready_i && (htrans_i == NONSEQ || htrans_i == SEQ);
   assign wr_fire  = wr_pend_q && hready_i;
   assign wrap     = ctrl_q[0] && (cnt_q >= cmp_q);   // compare reached
   assign stat_clr = wr_fire && off_q == TIMER_STAT && hwdata_i[0];

   ////////////////////////////////////////////////////////////////////////////
   // registers

   always_ff @(posedge hclk_i or negedge hreset_n_i) begin
      if (!hreset_n_i) begin
         ctrl_q    <= '0;
         cmp_q     <= '0;
         cnt_q     <= '0;
         stat_q    <= 1'b0;
         off_q     <= TIMER_CTRL;
         wr_pend_q <= 1'b0;
      end else begin
         if (hready_i) begin
            wr_pend_q <= accept && hwrite_i;
            if (accept) off_q <= timer_reg_t'(haddr_i[3:0]);
         end
         if (wrap)           cnt_q <= '0;
         else if (ctrl_q[0]) cnt_q <= cnt_q + 1'b1;   // one tick per clock
         if (wrap)          stat_q <= 1'b1;           // new match beats the clear
         else if (stat_clr) stat_q <= 1'b0;
         if (wr_fire) begin
            case (off_q)
               TIMER_CTRL: ctrl_q <= hwdata_i;
               TIMER_CMP:  cmp_q  <= hwdata_i;
               TIMER_CNT:  cnt_q  <= hwdata_i;        // bus wins over count
               default:    ;                          // stat handled above
            endcase
         end
      end
   end

   always_comb begin
      case (off_q)
         TIMER_CTRL: hrdata_o = ctrl_q;
         TIMER_CMP:  hrdata_o = cmp_q;
         TIMER_CNT:  hrdata_o = cnt_q;
         default:    hrdata_o = {{($bits(hdata_t)-1){1'b0}}, stat_q};
      endcase
   end

   assign irq_o = stat_q;

   // counter stays in range once running, after bus writes settle
   a_cnt_range: assert property (@(posedge hclk_i) disable iff (!hreset_n_i)
      ctrl_q[0] && $past(ctrl_q[0]) && !$past(wr_fire) |-> cnt_q <= cmp_q);

   a_word_only: assert property (@(posedge hclk_i) disable iff (!hreset_n_i)
      accept |-> hsize_i == HSIZE_WORD);

endmodule

// File: logic/fabric_top.sv
/*
 * single-master ahb-lite fabric
 * reset stretch, decoder, sram and timer slaves
 */
`timescale 1ns/1ns

module fabric_top import fabric_pkg::*; (
   input  logic    hclk_i,
   input  logic    rst_n_i,      // external async reset
   input  haddr_t  haddr_i,      // master address phase
   input  htrans_t htrans_i,
   input  hsize_t  hsize_i,
   input  logic    hwrite_i,
   input  hdata_t  hwdata_i,     // master data phase
   output hdata_t  hrdata_o,
   output logic    hready_o,
   output logic    hresp_o,
   output logic    irq_o         // timer match
);

   logic   hreset_n;             // stretched bus reset
   logic   sram_sel;
   logic   timer_sel;
   hdata_t sram_rdata;
   hdata_t timer_rdata;

   ////////////////////////////////////////////////////////////////////////////
   // reset and decode

   reset_stretch u_rst (
      .hclk_i     (hclk_i),
      .rst_n_i    (rst_n_i),
      .hreset_n_o (hreset_n)
   );

   ahb_decoder u_dec (
      .hclk_i        (hclk_i),
      .hreset_n_i    (hreset_n),
      .haddr_i       (haddr_i),
      .htrans_i      (htrans_i),
      .sram_rdata_i  (sram_rdata),
      .timer_rdata_i (timer_rdata),
      .sram_sel_o    (sram_sel),
      .timer_sel_o   (timer_sel),
      .hrdata_o      (hrdata_o),
      .hready_o      (hready_o),    // fans back out to the slaves
      .hresp_o       (hresp_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // slaves

   ahb_sram u_sram (
      .hclk_i (hclk_i), .hreset_n_i (hreset_n), .sel_i (sram_sel),
      .haddr_i (haddr_i), .htrans_i (htrans_i), .hsize_i (hsize_i),
      .hwrite_i (hwrite_i), .hwdata_i (hwdata_i), .hready_i (hready_o),
      .hrdata_o (sram_rdata)
   );

   ahb_timer u_timer (
      .hclk_i (hclk_i), .hreset_n_i (hreset_n), .sel_i (timer_sel),
      .haddr_i (haddr_i), .htrans_i (htrans_i), .hsize_i (hsize_i),
      .hwrite_i (hwrite_i), .hwdata_i (hwdata_i), .hready_i (hready_o),
      .hrdata_o (timer_rdata), .irq_o (irq_o)
   );

endmodule

// File: tests/fabric_tb.sv
/*
 * testbench for the ahb-lite fabric, acts as the only bus master
 * clock, reset, transfer table, master task, checks and watchdog
 */
`timescale 1ns/1ns
`include "fabric_settings.svh"

module fabric_tb import fabric_pkg::*; ();

   localparam int N_ENT = 20;       // table rows
   localparam int IRQ_LIMIT = 30;   // cycles allowed for the first match

   logic    hclk_i;
   logic    rst_n_i;
   haddr_t  haddr_i;
   htrans_t htrans_i;
   hsize_t  hsize_i;
   logic    hwrite_i;
   hdata_t  hwdata_i;
   hdata_t  hrdata_o;
   logic    hready_o;
   logic    hresp_o;
   logic    irq_o;

   // transfer table, one row per bus transfer
   logic   t_wr    [N_ENT];
   haddr_t t_addr  [N_ENT];
   hdata_t t_wdata [N_ENT];
   hdata_t t_exp   [N_ENT];
   logic   t_err   [N_ENT];
   hdata_t t_mask  [N_ENT];   // 0 for writes and don't-care reads
   int     n_fill;

   fabric_top dut0 (.*);

   initial begin
      hclk_i = 1'b0;
      forever #10 hclk_i = ~hclk_i;   // 20 ns period
   end

   ////////////////////////////////////////////////////////////////////////////
   // failure reporting and checks

   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (exp === act) else begin
         $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   function automatic haddr_t timer_addr(input timer_reg_t r);
      return `FABRIC_TIMER_BASE + haddr_t'(r);
   endfunction

   task automatic add_entry(input logic wr, input haddr_t addr, input hdata_t wdata,
                            input hdata_t exp, input logic err, input hdata_t mask);
      t_wr[n_fill]    = wr;
      t_addr[n_fill]  = addr;
      t_wdata[n_fill] = wdata;
      t_exp[n_fill]   = exp;
      t_err[n_fill]   = err;
      t_mask[n_fill]  = mask;
      n_fill++;
   endtask

   // one transfer, address phase then data phase, idle after it
   // returns at the sample point just before the edge that ends the data phase
   task automatic run_transfer(input logic wr, input haddr_t addr, input hdata_t wdata,
                               output hdata_t rdata, output logic err, output int stalls);
      @(negedge hclk_i);
      haddr_i  = addr;
      htrans_i = NONSEQ;
      hwrite_i = wr;
      hsize_i  = HSIZE_WORD;
      #9;
      while (!hready_o) begin       // hold address phase over a stall
         @(negedge hclk_i);
         #9;
      end
      @(negedge hclk_i);
      htrans_i = IDLE;
      hwdata_i = wdata;             // data phase
      stalls   = 0;
      #9;
      while (!hready_o) begin
         check_value("hresp_o", 1'b1, hresp_o);   // first error cycle
         stalls++;
         @(negedge hclk_i);
         #9;
      end
      rdata = hrdata_o;
      err   = hresp_o;
   endtask

   task automatic build_table();
      hdata_t w [4];
      foreach (w[k]) w[k] = $urandom;
      n_fill = 0;
      // sram writes and readback, then alias at +512 words
      add_entry(1, `FABRIC_SRAM_BASE + 32'h000, w[0], 0, 0, 0);
      add_entry(1, `FABRIC_SRAM_BASE + 32'h010, w[1], 0, 0, 0);
      add_entry(1, `FABRIC_SRAM_BASE + 32'h400, w[2], 0, 0, 0);
      add_entry(1, `FABRIC_SRAM_BASE + 32'h7FC, w[3], 0, 0, 0);
      add_entry(0, `FABRIC_SRAM_BASE + 32'h000, 0, w[0], 0, '1);
      add_entry(0, `FABRIC_SRAM_BASE + 32'h010, 0, w[1], 0, '1);
      add_entry(0, `FABRIC_SRAM_BASE + 32'h400, 0, w[2], 0, '1);
      add_entry(0, `FABRIC_SRAM_BASE + 32'h7FC, 0, w[3], 0, '1);
      add_entry(0, `FABRIC_SRAM_BASE + 32'h800, 0, w[0], 0, '1);
      add_entry(0, `FABRIC_SRAM_BASE + 32'h810, 0, w[1], 0, '1);
      // unmapped, then sram again
      add_entry(0, 32'h1000_0000, 0, 0, 1, 0);
      add_entry(0, `FABRIC_SRAM_BASE + 32'h400, 0, w[2], 0, '1);
      // timer registers, enable bit kept low
      add_entry(0, timer_addr(TIMER_CNT), 0, 0, 0, '1);
      add_entry(1, timer_addr(TIMER_CMP), 32'h1234_5678, 0, 0, 0);
      add_entry(0, timer_addr(TIMER_CMP), 0, 32'h1234_5678, 0, '1);
      add_entry(1, timer_addr(TIMER_CTRL), 32'h0000_00A6, 0, 0, 0);
      add_entry(0, timer_addr(TIMER_CTRL), 0, 32'h0000_00A6, 0, '1);
      add_entry(0, timer_addr(TIMER_CNT), 0, 0, 0, '1);
      add_entry(1, timer_addr(TIMER_CMP), 32'd20, 0, 0, 0);
      add_entry(0, timer_addr(TIMER_CMP), 0, 32'd20, 0, '1);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      hdata_t rdata;
      logic   err;
      int     stalls;
      int     waited;
      rst_n_i  = 1'b0;
      haddr_i  = '0;
      htrans_i = IDLE;
      hsize_i  = HSIZE_WORD;
      hwrite_i = 1'b0;
      hwdata_i = '0;
      void'($urandom(32'hd75b_e3ba));
      build_table();
      check_value("table rows", N_ENT, n_fill);

      repeat (8) @(posedge hclk_i);
      @(negedge hclk_i);
      rst_n_i = 1'b1;                  // release on a falling edge
      repeat (`FABRIC_RST_STRETCH) begin
         #9;
         check_value("hready_o", 1'b0, hready_o);   // still stretched
         @(negedge hclk_i);
      end
      #9;
      check_value("hready_o", 1'b1, hready_o);
      check_value("irq_o", 1'b0, irq_o);
      check_value("hresp_o", 1'b0, hresp_o);

      for (int i = 0; i < N_ENT; i++) begin
         run_transfer(t_wr[i], t_addr[i], t_wdata[i], rdata, err, stalls);
         check_value("hresp_o", t_err[i], err);
         check_value("error stall cycles", t_err[i] ? 1 : 0, stalls);
         check_value("hrdata_o", t_exp[i] & t_mask[i], rdata & t_mask[i]);
      end

      // timer match with cmp = 20
      run_transfer(1, timer_addr(TIMER_CTRL), 32'd1, rdata, err, stalls);
      waited = 0;
      while (!irq_o && waited < IRQ_LIMIT) begin
         @(negedge hclk_i);
         #9;
         waited++;
      end
      assert (irq_o) else begin
         $display("irq_o did not rise within %0d cycles of enabling the timer", IRQ_LIMIT);
         abort_run();
      end
      run_transfer(0, timer_addr(TIMER_STAT), 0, rdata, err, stalls);
      check_value("hrdata_o", 32'd1, rdata);
      run_transfer(1, timer_addr(TIMER_STAT), 32'd1, rdata, err, stalls);   // w1c
      @(negedge hclk_i);
      #9;
      check_value("irq_o", 1'b0, irq_o);
      run_transfer(0, timer_addr(TIMER_STAT), 0, rdata, err, stalls);
      check_value("hrdata_o", 32'd0, rdata);

      $display("Simulation PASSED");
      $finish;
   end

   // run length scales with the table
   initial begin
      repeat (N_ENT * 10 + 400) @(posedge hclk_i);
      $display("watchdog expired before the test sequence finished");
      abort_run();
   end

endmodule

// File: files.f
+incdir+logic
logic/fabric_pkg.sv
logic/reset_stretch.sv
logic/ahb_decoder.sv
logic/ahb_sram.sv
logic/ahb_timer.sv
logic/fabric_top.sv
tests/fabric_tb.sv

// File: Bender.yml
package:
  name: fabric

sources:
  - include_dirs:
      - logic
    files:
      - logic/fabric_pkg.sv
      - logic/reset_stretch.sv
      - logic/ahb_decoder.sv
      - logic/ahb_sram.sv
      - logic/ahb_timer.sv
      - logic/fabric_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/fabric_tb.sv
